// ==== all.f ====
src/xvid_pkg.sv
src/xvid_bus_decode.sv
src/xvid_reg_file.sv
src/xvid_init_clear.sv
src/xvid_vram_port.sv
src/xvid_blitter.sv
test/tb_xvid_blitter.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the blitter testbench with Verilator, pass is decided from the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f all.f \
    --top-module tb_xvid_blitter -o tb_sim > build.log 2>&1 \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    && grep -qx "TB PASSED" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }

// ==== src/xvid_blitter.sv ====
// blitter top level, bus decode to register file to vram port, plus start-up clear
`default_nettype none
`timescale 1ns/1ns

module xvid_blitter import xvid_pkg::*; #(
    parameter int                CLEAR_WORDS = 65536,
    parameter logic [WORD_W-1:0] CLEAR_DATA  = 16'h1F20
) (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               bus_cs_n_i,
    input  logic               bus_rd_nwr_i,
    input  logic [3:0]         bus_reg_num_i,
    input  logic               bus_bytesel_i,
    input  logic [BYTE_W-1:0]  bus_data_i,
    output logic [BYTE_W-1:0]  bus_data_o,
    input  logic               blit_cycle_i,    // 1 = blitter slot
    output logic               video_ena_o,
    output logic               vram_sel_o,
    output logic               vram_wr_o,
    output logic [VRAM_AW-1:0] vram_addr_o,
    input  logic [WORD_W-1:0]  vram_data_i,
    output logic [WORD_W-1:0]  vram_data_o
);

    xvid_reg_t          bus_reg_num;
    logic               wr_strobe;
    xvid_reg_t          wr_reg_num;
    logic               wr_odd;
    logic [WORD_W-1:0]  wr_word;
    logic               cmd_valid;
    logic               cmd_wr;
    logic [VRAM_AW-1:0] cmd_addr;
    logic [WORD_W-1:0]  cmd_data;
    logic               port_busy;
    logic               rd_done;
    logic               wr_done;
    logic [WORD_W-1:0]  rd_word;
    logic               init_req;
    logic [VRAM_AW-1:0] init_addr;
    logic [WORD_W-1:0]  init_data;
    logic               init_done;

    assign bus_reg_num = xvid_reg_t'(bus_reg_num_i);   // all 16 codes are named

    xvid_bus_decode u_decode (
        .clk(clk), .reset_i(reset_i),
        .bus_cs_n_i(bus_cs_n_i), .bus_rd_nwr_i(bus_rd_nwr_i),
        .bus_reg_num_i(bus_reg_num), .bus_bytesel_i(bus_bytesel_i), .bus_data_i(bus_data_i),
        .wr_strobe_o(wr_strobe), .wr_reg_num_o(wr_reg_num),
        .wr_odd_o(wr_odd), .wr_word_o(wr_word)
    );

    xvid_reg_file u_regs (
        .clk(clk), .reset_i(reset_i),
        .wr_strobe_i(wr_strobe), .wr_reg_num_i(wr_reg_num),
        .wr_odd_i(wr_odd), .wr_word_i(wr_word),
        .bus_reg_num_i(bus_reg_num), .bus_bytesel_i(bus_bytesel_i),
        .init_done_i(init_done), .port_busy_i(port_busy),
        .rd_done_i(rd_done), .wr_done_i(wr_done), .rd_word_i(rd_word),
        .bus_data_o(bus_data_o),
        .cmd_valid_o(cmd_valid), .cmd_wr_o(cmd_wr),
        .cmd_addr_o(cmd_addr), .cmd_data_o(cmd_data)
    );

    xvid_init_clear #(
        .CLEAR_WORDS(CLEAR_WORDS),
        .CLEAR_DATA(CLEAR_DATA)
    ) u_init (
        .clk(clk), .reset_i(reset_i), .wr_done_i(wr_done),
        .init_req_o(init_req), .init_addr_o(init_addr), .init_data_o(init_data),
        .init_done_o(init_done), .video_ena_o(video_ena_o)
    );

    xvid_vram_port u_port (
        .clk(clk), .reset_i(reset_i), .blit_cycle_i(blit_cycle_i),
        .init_req_i(init_req), .init_addr_i(init_addr), .init_data_i(init_data),
        .cmd_valid_i(cmd_valid), .cmd_wr_i(cmd_wr),
        .cmd_addr_i(cmd_addr), .cmd_data_i(cmd_data),
        .vram_data_i(vram_data_i),
        .vram_sel_o(vram_sel_o), .vram_wr_o(vram_wr_o),
        .vram_addr_o(vram_addr_o), .vram_data_o(vram_data_o),
        .port_busy_o(port_busy), .rd_done_o(rd_done),
        .rd_word_o(rd_word), .wr_done_o(wr_done)
    );

endmodule

`default_nettype wire

// ==== src/xvid_bus_decode.sv ====
// host bus byte sampling, even byte latch and registered word write event
`default_nettype none
`timescale 1ns/1ns

module xvid_bus_decode import xvid_pkg::*; (
    input  logic              clk,
    input  logic              reset_i,
    input  logic              bus_cs_n_i,       // chip select, active low
    input  logic              bus_rd_nwr_i,     // 1 = read, 0 = write
    input  xvid_reg_t         bus_reg_num_i,
    input  logic              bus_bytesel_i,    // 0 = even (high) byte
    input  logic [BYTE_W-1:0] bus_data_i,
    output logic              wr_strobe_o,      // one pulse per byte written
    output xvid_reg_t         wr_reg_num_o,
    output logic              wr_odd_o,
    output logic [WORD_W-1:0] wr_word_o         // even latch joined with new byte
);

    logic              byte_wr;
    logic [BYTE_W-1:0] even_q;                  // last even byte from the host

    assign byte_wr = !bus_cs_n_i && !bus_rd_nwr_i;  // every selected write cycle is one byte

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_strobe_o <= 1'b0;
        end else begin
            wr_strobe_o <= byte_wr;
        end
    end

    // payload follows the strobe, held between writes
    always_ff @(posedge clk) begin
        if (byte_wr) begin
            wr_reg_num_o <= bus_reg_num_i;
            wr_odd_o     <= bus_bytesel_i;
            if (bus_bytesel_i) begin
                wr_word_o <= {even_q, bus_data_i};      // completes the word
            end else begin
                even_q    <= bus_data_i;
                wr_word_o <= {bus_data_i, bus_data_i};  // only the high half is used
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/xvid_init_clear.sv ====
// start-up vram clear engine and video enable
`default_nettype none
`timescale 1ns/1ns

module xvid_init_clear import xvid_pkg::*; #(
    parameter int                CLEAR_WORDS = 65536,
    parameter logic [WORD_W-1:0] CLEAR_DATA  = 16'h1F20
) (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               wr_done_i,       // port finished a clear write
    output logic               init_req_o,
    output logic [VRAM_AW-1:0] init_addr_o,
    output logic [WORD_W-1:0]  init_data_o,
    output logic               init_done_o,
    output logic               video_ena_o
);

    localparam logic [VRAM_AW-1:0] LAST_ADDR = VRAM_AW'(CLEAR_WORDS - 1);

    init_state_t        state_q;
    logic [VRAM_AW-1:0] addr_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= INIT;
        end else begin
            case (state_q)
                INIT: begin
                    state_q <= CLEAR;
                end
                CLEAR: begin
                    if (wr_done_i && addr_q == LAST_ADDR) begin
                        state_q <= READY;
                    end
                end
                default: begin
                    state_q <= READY;           // stays until reset
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == INIT) begin
            addr_q <= '0;
        end else if (state_q == CLEAR && wr_done_i) begin
            addr_q <= addr_q + 1'b1;
        end
    end

    assign init_req_o  = (state_q == CLEAR);    // level, port picks it up when idle
    assign init_addr_o = addr_q;
    assign init_data_o = CLEAR_DATA;
    assign init_done_o = (state_q == READY);
    assign video_ena_o = (state_q == READY);

endmodule

`default_nettype wire

// ==== src/xvid_pkg.sv ====
// register numbers, clear-engine states and bus/memory widths shared by the blitter
`default_nettype none

package xvid_pkg;

    localparam int VRAM_AW = 16;                // vram address width
    localparam int WORD_W  = 16;                // register and vram word
    localparam int BYTE_W  = 8;                 // host bus width

    // host visible register numbers
    typedef enum logic [3:0] {
        RD_INC,                                 // read address increment
        WR_INC,                                 // write address increment
        RD_MOD,
        WR_MOD,
        WIDTH,
        RD_ADDR,                                // odd byte write starts a read
        WR_ADDR,
        DATA,                                   // odd byte write starts a write
        DATA_2,                                 // read word comes back here
        COUNT,
        VID_CTRL,
        VID_DATA,
        AUX_RD_ADDR,
        AUX_WR_ADDR,
        AUX_CTRL,
        AUX_DATA
    } xvid_reg_t;

    typedef enum logic [1:0] {
        INIT,                                   // one cycle to zero the address
        CLEAR,                                  // fill memory with clear value
        READY                                   // video on, host commands accepted
    } init_state_t;

endpackage

`default_nettype wire

// ==== src/xvid_reg_file.sv ====
// register bank 0-7, address auto increment, vram command issue and bus read mux
`default_nettype none
`timescale 1ns/1ns

module xvid_reg_file import xvid_pkg::*; (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               wr_strobe_i,
    input  xvid_reg_t          wr_reg_num_i,
    input  logic               wr_odd_i,
    input  logic [WORD_W-1:0]  wr_word_i,
    input  xvid_reg_t          bus_reg_num_i,
    input  logic               bus_bytesel_i,
    input  logic               init_done_i,
    input  logic               port_busy_i,
    input  logic               rd_done_i,
    input  logic               wr_done_i,
    input  logic [WORD_W-1:0]  rd_word_i,
    output logic [BYTE_W-1:0]  bus_data_o,
    output logic               cmd_valid_o,     // one cycle pulse to the port
    output logic               cmd_wr_o,        // 1 = write, 0 = read
    output logic [VRAM_AW-1:0] cmd_addr_o,
    output logic [WORD_W-1:0]  cmd_data_o
);

    localparam logic [2:0] I_RD_INC  = 3'(RD_INC);
    localparam logic [2:0] I_WR_INC  = 3'(WR_INC);
    localparam logic [2:0] I_RD_ADDR = 3'(RD_ADDR);
    localparam logic [2:0] I_WR_ADDR = 3'(WR_ADDR);

    logic [WORD_W-1:0] regs_q [0:7];
    logic [WORD_W-1:0] data2_q;                 // last word read from vram
    logic [WORD_W-1:0] rd_sel;
    logic              host_wr;
    logic              can_issue;

    assign host_wr   = wr_strobe_i && init_done_i;  // host ignored while memory clears
    assign can_issue = host_wr && wr_odd_i && !port_busy_i && !cmd_valid_o;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < 8; i++) begin
                regs_q[i] <= '0;
            end
            data2_q     <= '0;
            cmd_valid_o <= 1'b0;
            cmd_wr_o    <= 1'b0;
        end else begin
            cmd_valid_o <= 1'b0;
            if (!init_done_i) begin
                regs_q[I_WR_INC] <= 16'h0001;   // default step during start-up
            end
            if (rd_done_i) begin
                data2_q           <= rd_word_i;
                regs_q[I_RD_ADDR] <= regs_q[I_RD_ADDR] + regs_q[I_RD_INC];
            end
            if (wr_done_i && init_done_i) begin     // clear writes do not move WR_ADDR
                regs_q[I_WR_ADDR] <= regs_q[I_WR_ADDR] + regs_q[I_WR_INC];
            end
            if (host_wr && !wr_reg_num_i[3]) begin
                if (wr_odd_i) begin
                    regs_q[wr_reg_num_i[2:0]][7:0]  <= wr_word_i[7:0];
                end else begin
                    regs_q[wr_reg_num_i[2:0]][15:8] <= wr_word_i[15:8];
                end
            end
            if (can_issue) begin
                case (wr_reg_num_i)
                    RD_ADDR: begin
                        cmd_valid_o <= 1'b1;
                        cmd_wr_o    <= 1'b0;
                        cmd_addr_o  <= {regs_q[I_RD_ADDR][15:8], wr_word_i[7:0]};
                    end
                    DATA, DATA_2: begin
                        cmd_valid_o <= 1'b1;
                        cmd_wr_o    <= 1'b1;
                        cmd_addr_o  <= regs_q[I_WR_ADDR];
                        cmd_data_o  <= wr_word_i;
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // fresh read word bypasses the store so DATA_2 shows it a cycle earlier
    always_comb begin
        rd_sel = '0;
        if (!bus_reg_num_i[3]) begin
            rd_sel = regs_q[bus_reg_num_i[2:0]];
        end else if (bus_reg_num_i == DATA_2) begin
            rd_sel = rd_done_i ? rd_word_i : data2_q;
        end
        bus_data_o = bus_bytesel_i ? rd_sel[7:0] : rd_sel[15:8];
    end

    // port takes one access at a time, commands must never hit a held access
    cmd_while_busy_a: assert property (@(posedge clk) disable iff (reset_i)
        !(cmd_valid_o && port_busy_i));

endmodule

`default_nettype wire

// ==== src/xvid_vram_port.sv ====
// slot granted vram access holder with read data capture
`default_nettype none
`timescale 1ns/1ns

module xvid_vram_port import xvid_pkg::*; (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               blit_cycle_i,    // slot grant from the video side
    input  logic               init_req_i,
    input  logic [VRAM_AW-1:0] init_addr_i,
    input  logic [WORD_W-1:0]  init_data_i,
    input  logic               cmd_valid_i,
    input  logic               cmd_wr_i,
    input  logic [VRAM_AW-1:0] cmd_addr_i,
    input  logic [WORD_W-1:0]  cmd_data_i,
    input  logic [WORD_W-1:0]  vram_data_i,
    output logic               vram_sel_o,
    output logic               vram_wr_o,
    output logic [VRAM_AW-1:0] vram_addr_o,
    output logic [WORD_W-1:0]  vram_data_o,
    output logic               port_busy_o,
    output logic               rd_done_o,
    output logic [WORD_W-1:0]  rd_word_o,
    output logic               wr_done_o
);

    logic grant;
    logic rd_wait_q;                            // memory presents read data this cycle
    logic take_init;
    logic take_cmd;

    assign grant       = vram_sel_o && blit_cycle_i;
    // busy through the done pulse so a level request is not taken twice
    assign port_busy_o = vram_sel_o || rd_wait_q || rd_done_o || wr_done_o;
    assign take_init   = !port_busy_o && init_req_i;   // clear has priority
    assign take_cmd    = !port_busy_o && !init_req_i && cmd_valid_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            vram_sel_o <= 1'b0;
            vram_wr_o  <= 1'b0;
            rd_wait_q  <= 1'b0;
            rd_done_o  <= 1'b0;
            wr_done_o  <= 1'b0;
        end else begin
            wr_done_o <= grant && vram_wr_o;
            rd_wait_q <= grant && !vram_wr_o;
            rd_done_o <= rd_wait_q;
            if (grant) begin
                vram_sel_o <= 1'b0;
                vram_wr_o  <= 1'b0;
            end else if (take_init) begin
                vram_sel_o <= 1'b1;
                vram_wr_o  <= 1'b1;
            end else if (take_cmd) begin
                vram_sel_o <= 1'b1;
                vram_wr_o  <= cmd_wr_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take_init) begin
            vram_addr_o <= init_addr_i;
            vram_data_o <= init_data_i;
        end else if (take_cmd) begin
            vram_addr_o <= cmd_addr_i;
            vram_data_o <= cmd_data_i;
        end
        if (rd_wait_q) begin
            rd_word_o <= vram_data_i;
        end
    end

    // held access must not change until the slot grant ends it
    hold_stable_a: assert property (@(posedge clk) disable iff (reset_i)
        vram_sel_o && !blit_cycle_i |=>
            vram_sel_o && $stable(vram_addr_o) && $stable(vram_data_o));

endmodule

`default_nettype wire

// ==== test/tb_xvid_blitter.sv ====
// testbench for xvid_blitter with vram model, reference memory and checker
`default_nettype none
`timescale 1ns/1ns

module tb_xvid_blitter import xvid_pkg::*; ();

    localparam int LIMIT = 2000;                // cycles allowed for any single wait

    logic        clk;
    logic        reset_i;
    logic        bus_cs_n_i;
    logic        bus_rd_nwr_i;
    logic [3:0]  bus_reg_num_i;
    logic        bus_bytesel_i;
    logic [7:0]  bus_data_i;
    logic [7:0]  bus_data_o;
    logic        blit_cycle_i;
    logic        video_ena_o;
    logic        vram_sel_o;
    logic        vram_wr_o;
    logic [15:0] vram_addr_o;
    logic [15:0] vram_data_i;
    logic [15:0] vram_data_o;
    logic [15:0] vram [0:255];                  // memory model behind the port
    logic [15:0] ref_mem [0:255];               // expected memory contents
    int          seed = 89093;
    int          errors = 0;
    int          checks = 0;
    int          tests_done = 0;
    int          tests_failed = 0;
    int          err_mark = 0;

    xvid_blitter #(.CLEAR_WORDS(64), .CLEAR_DATA(16'h1F20)) u_dut (
        .clk(clk), .reset_i(reset_i),
        .bus_cs_n_i(bus_cs_n_i), .bus_rd_nwr_i(bus_rd_nwr_i), .bus_reg_num_i(bus_reg_num_i),
        .bus_bytesel_i(bus_bytesel_i), .bus_data_i(bus_data_i), .bus_data_o(bus_data_o),
        .blit_cycle_i(blit_cycle_i), .video_ena_o(video_ena_o),
        .vram_sel_o(vram_sel_o), .vram_wr_o(vram_wr_o), .vram_addr_o(vram_addr_o),
        .vram_data_i(vram_data_i), .vram_data_o(vram_data_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        blit_cycle_i <= 1'($random(seed));      // random slot grant
        if (vram_sel_o && blit_cycle_i) begin
            if (vram_wr_o) begin
                vram[vram_addr_o[7:0]] <= vram_data_o;
            end else begin
                vram_data_i <= vram[vram_addr_o[7:0]];  // data on the cycle after grant
            end
        end
    end

    // address auto increment rule wrapping at the 16-bit address width
    function automatic logic [15:0] next_addr(input logic [15:0] addr, input logic [15:0] inc);
        return addr + inc;
    endfunction

    task automatic check(input string name, input logic [15:0] expected,
                         input logic [15:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("[FAIL] %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic finish_test(input string name);
        tests_done++;
        if (errors != err_mark) begin
            tests_failed++;
            $display("test %s: failed", name);
        end else begin
            $display("test %s: ok", name);
        end
        err_mark = errors;
    endtask

    task automatic write_byte(input logic [3:0] r, input logic odd, input logic [7:0] d);
        @(posedge clk);
        bus_cs_n_i    <= 1'b0;
        bus_rd_nwr_i  <= 1'b0;
        bus_reg_num_i <= r;
        bus_bytesel_i <= odd;
        bus_data_i    <= d;
        @(posedge clk);
        bus_cs_n_i    <= 1'b1;                  // one cycle is one byte
        bus_rd_nwr_i  <= 1'b1;
    endtask

    task automatic write_reg(input logic [3:0] r, input logic [15:0] w);
        write_byte(r, 1'b0, w[15:8]);
        write_byte(r, 1'b1, w[7:0]);            // odd byte completes the word
    endtask

    task automatic read_reg(input logic [3:0] r, output logic [15:0] w);
        @(posedge clk);
        bus_reg_num_i <= r;
        bus_bytesel_i <= 1'b0;
        @(negedge clk);
        w[15:8] = bus_data_o;
        @(posedge clk);
        bus_bytesel_i <= 1'b1;
        @(negedge clk);
        w[7:0] = bus_data_o;
    endtask

    // counts cycles from the odd byte to sel, then waits for the grant and its done pulse
    task automatic wait_access(input string name, output int lat);
        int n;
        n = 0;
        lat = 1;
        @(negedge clk);
        while (!vram_sel_o && n < LIMIT) begin
            @(posedge clk);
            lat++;
            @(negedge clk);
            n++;
        end
        while (!blit_cycle_i && n < LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (n >= LIMIT) begin
            errors++;
            $display("%s: no vram access completed within %0d cycles", name, LIMIT);
        end else begin
            repeat (3) @(posedge clk);          // covers the done pulse and the address increment
        end
    endtask

    task automatic compare_memory(input string name);
        for (int i = 0; i < 256; i++) begin
            check(name, ref_mem[i], vram[i]);
        end
    endtask

    initial begin
        logic [15:0] word;
        logic [15:0] addr;
        logic [15:0] wdata;
        logic [7:0]  a;
        logic        use_d2;
        int          lat;
        int          op;
        int          n;
        for (int i = 0; i < 256; i++) begin
            vram[i]    = 16'(i * 16'h0101) ^ 16'hA5C3;
            ref_mem[i] = 16'(i * 16'h0101) ^ 16'hA5C3;
        end
        reset_i       = 1'b1;
        bus_cs_n_i    = 1'b1;
        bus_rd_nwr_i  = 1'b1;
        bus_reg_num_i = 4'h0;
        bus_bytesel_i = 1'b0;
        bus_data_i    = 8'h00;
        blit_cycle_i  = 1'b0;
        vram_data_i   = 16'h0000;
        repeat (5) @(posedge clk);
        reset_i <= 1'b0;

        // start-up clear
        n = 0;
        @(negedge clk);
        while (!video_ena_o && n < LIMIT * 10) begin
            @(negedge clk);
            n++;
        end
        if (!video_ena_o) begin
            errors++;
            $display("video enable did not rise after reset");
        end
        for (int i = 0; i < 64; i++) begin
            ref_mem[i] = 16'h1F20;
        end
        compare_memory("clear");
        finish_test("clear");

        // register read-back
        read_reg(WR_INC, word);
        check("wr_inc after init", 16'h0001, word);
        write_reg(RD_INC, 16'h1234);
        write_reg(WR_INC, 16'h5678);
        write_reg(WR_MOD, 16'hABCD);
        read_reg(RD_INC, word);
        check("rd_inc readback", 16'h1234, word);
        read_reg(WR_INC, word);
        check("wr_inc readback", 16'h5678, word);
        read_reg(WR_MOD, word);
        check("wr_mod readback", 16'hABCD, word);
        for (int r = 9; r < 16; r++) begin
            write_reg(4'(r), 16'hFFFF);
        end
        for (int r = 9; r < 16; r++) begin
            read_reg(4'(r), word);
            check("unused reg", 16'h0000, word);
        end
        finish_test("readback");

        // vram writes through DATA with WR_INC of 3
        addr = 16'h0010;
        write_reg(WR_INC, 16'h0003);
        write_reg(WR_ADDR, addr);
        for (int i = 0; i < 4; i++) begin
            wdata = 16'hB000 + 16'(i * 16'h0111);
            write_reg(DATA, wdata);
            wait_access("data write", lat);
            check("sel latency", 16'd3, 16'(lat));
            ref_mem[addr[7:0]] = wdata;
            addr = next_addr(addr, 16'h0003);
        end
        read_reg(WR_ADDR, word);
        check("wr_addr advance", addr, word);
        compare_memory("data write");
        finish_test("write");

        // vram reads through RD_ADDR and DATA_2
        addr = 16'h0010;
        write_reg(RD_INC, 16'h0002);
        for (int i = 0; i < 3; i++) begin
            write_reg(RD_ADDR, addr);
            wait_access("rd_addr read", lat);
            read_reg(DATA_2, word);
            check("read data", ref_mem[addr[7:0]], word);
            read_reg(RD_ADDR, word);
            check("rd_addr advance", next_addr(addr, 16'h0002), word);
            addr = addr + 16'h0035;
        end
        finish_test("read");

        // random writes and reads, one access at a time
        for (int i = 0; i < 20; i++) begin
            @(negedge clk);
            op     = $random(seed) & 1;
            use_d2 = 1'($random(seed));
            a      = 8'($random(seed));
            wdata  = 16'($random(seed));
            if (op == 0) begin
                write_reg(WR_ADDR, {8'h00, a});
                write_reg(use_d2 ? DATA_2 : DATA, wdata);
                wait_access("random write", lat);
                ref_mem[a] = wdata;
            end else begin
                write_reg(RD_ADDR, {8'h00, a});
                wait_access("random read", lat);
                read_reg(DATA_2, word);
                check("random read", ref_mem[a], word);
            end
        end
        compare_memory("random memory");
        finish_test("random");

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_done, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
